// ==== rtl/riscv_pkg.sv ====
////////////////////
// shared types and constants for the RV32I pipeline control core
// import with riscv_pkg::* in the module header where needed
////////////////////

package riscv_pkg;

    // data and address width
    localparam int XLEN = 32;

    // per-stage command from the hazard unit
    // a stage register loads a bubble on FLUSH, the PC loads the jump target
    typedef enum logic [1:0] {
        ENABLE = 2'b00,
        STALL  = 2'b01,
        FLUSH  = 2'b10
    } hazard_ctrl_e;

    // fetch redirect request from decode
    typedef enum logic {
        NO_JUMP = 1'b0,
        JUMP    = 1'b1
    } if_ctrl_e;

    // data memory access direction
    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } mem_wr_e;

    typedef struct packed {
        logic    mem_en;
        mem_wr_e wr;
    } mem_ctrl_t;

    // stage payloads, valid first and all-zero means bubble

    // fetch to decode, 65 bits
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } if_dec_t;

    // decode to execute, 40 bits
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        mem_ctrl_t       mem;
    } dec_ex_t;

    // execute to memory, same layout as decode to execute
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        mem_ctrl_t       mem;
    } ex_mem_t;

    // memory to writeback, feeds the retirement stream
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
    } retire_t;

    // major opcodes handled by the decoder
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;

endpackage

// ==== rtl/pipe_reg.sv ====
////////////////////
// stage register for any payload type
// ENABLE loads, STALL holds, FLUSH or reset loads a bubble
////////////////////

`timescale 1ns/1ps

module pipe_reg import riscv_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic         CLK,
    input  logic         RSTn,
    input  hazard_ctrl_e ctrl,
    input  payload_t     d,
    output payload_t     q
);

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            q <= '0;
        end else begin
            case (ctrl)
                ENABLE: q <= d;
                FLUSH:  q <= '0;
                // STALL keeps the current payload
                default: q <= q;
            endcase
        end
    end

endmodule

// ==== rtl/fetch_pc.sv ====
////////////////////
// program counter and fetch payload
// the word on instr_rdata belongs to the current pc
////////////////////

`timescale 1ns/1ps

module fetch_pc import riscv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000
) (
    input  logic            CLK,
    input  logic            RSTn,
    input  hazard_ctrl_e    ctrl,
    input  logic [XLEN-1:0] jump_target,
    input  logic [XLEN-1:0] instr_rdata,
    output logic [XLEN-1:0] pc,
    output if_dec_t         fetch
);

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            pc <= RESET_PC;
        end else begin
            case (ctrl)
                ENABLE: pc <= pc + 32'd4;
                // FLUSH on the pc means redirect
                FLUSH:  pc <= jump_target;
                default: pc <= pc;
            endcase
        end
    end

    // fetched word is always a real instruction
    assign fetch = '{
        valid: 1'b1,
        pc:    pc,
        instr: instr_rdata
    };

endmodule

// ==== rtl/decoder.sv ====
////////////////////
// RV32I decode for the control skeleton
// register fields, memory control and JAL target
////////////////////

`timescale 1ns/1ps

module decoder import riscv_pkg::*; (
    input  if_dec_t         stage_in,
    output dec_ex_t         stage_out,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic            use_rs1,
    output logic            use_rs2,
    output if_ctrl_e        branch_cond,
    output logic [XLEN-1:0] jump_target
);

    logic [6:0]      opcode;
    logic [XLEN-1:0] j_imm;

    assign opcode = stage_in.instr[6:0];
    assign rs1    = stage_in.instr[19:15];
    assign rs2    = stage_in.instr[24:20];

    // J-type immediate, bit 0 always zero
    assign j_imm = {{11{stage_in.instr[31]}}, stage_in.instr[31], stage_in.instr[19:12],
                    stage_in.instr[20], stage_in.instr[30:21], 1'b0};
    assign jump_target = stage_in.pc + j_imm;

    always_comb begin
        stage_out   = '0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        branch_cond = NO_JUMP;
        // a bubble in gives a bubble out
        if (stage_in.valid) begin
            stage_out.valid = 1'b1;
            stage_out.pc    = stage_in.pc;
            case (opcode)
                OPC_LOAD: begin
                    use_rs1        = 1'b1;
                    stage_out.rd   = stage_in.instr[11:7];
                    stage_out.mem  = '{mem_en: 1'b1, wr: READ};
                end
                OPC_STORE: begin
                    use_rs1        = 1'b1;
                    use_rs2        = 1'b1;
                    stage_out.mem  = '{mem_en: 1'b1, wr: WRITE};
                end
                OPC_OP: begin
                    use_rs1        = 1'b1;
                    use_rs2        = 1'b1;
                    stage_out.rd   = stage_in.instr[11:7];
                end
                OPC_OPIMM: begin
                    use_rs1        = 1'b1;
                    stage_out.rd   = stage_in.instr[11:7];
                end
                OPC_JAL: begin
                    stage_out.rd   = stage_in.instr[11:7];
                    branch_cond    = JUMP;
                end
                // anything else flows through as a no-op
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/hazard_unit.sv ====
////////////////////
// hazard unit: per-stage enable/stall/flush and memory request levels
// freezes the pipeline while either memory is busy
////////////////////

`timescale 1ns/1ps

module hazard_unit import riscv_pkg::*; (
    input  logic         CLK,
    input  logic         RSTn,
    // decode stage
    input  if_ctrl_e     branch_cond,
    input  logic [4:0]   dec_rs1,
    input  logic [4:0]   dec_rs2,
    input  logic         dec_use_rs1,
    input  logic         dec_use_rs2,
    // execute stage (dec_ex register)
    input  logic [4:0]   ex_rd,
    input  mem_ctrl_t    ex_mem_op,
    input  logic         ex_valid,
    // memory stage (ex_mem register)
    input  mem_ctrl_t    mem_mem_ctrl,
    input  logic         mem_valid,
    // memory status
    input  logic         instr_mem_busy,
    input  logic         data_mem_busy,
    // memory requests
    output logic         instr_req,
    output logic         data_req,
    output logic         data_we,
    // stage commands
    output hazard_ctrl_e pc_ctrl,
    output hazard_ctrl_e if_dec_ctrl,
    output hazard_ctrl_e dec_ex_ctrl,
    output hazard_ctrl_e ex_mem_ctrl,
    output hazard_ctrl_e mem_wb_ctrl
);

    typedef enum logic [1:0] {
        issue,
        instr_busy,
        data_busy
    } hu_state_e;

    hu_state_e state, state_nxt;

    logic load_in_ex;
    logic load_use;
    logic mem_access;

    // load in execute that writes a real register
    assign load_in_ex = ex_valid && ex_mem_op.mem_en && (ex_mem_op.wr == READ)
                        && (ex_rd != 5'd0);
    assign load_use   = load_in_ex && ((dec_use_rs1 && (dec_rs1 == ex_rd))
                                    || (dec_use_rs2 && (dec_rs2 == ex_rd)));
    assign mem_access = mem_valid && mem_mem_ctrl.mem_en;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            state <= issue;
        end else begin
            state <= state_nxt;
        end
    end

    // instruction side busy wins over data side
    always_comb begin
        state_nxt = state;
        case (state)
            issue: begin
                if (instr_mem_busy) begin
                    state_nxt = instr_busy;
                end else if (data_mem_busy) begin
                    state_nxt = data_busy;
                end
            end
            instr_busy: begin
                if (!instr_mem_busy) begin
                    state_nxt = issue;
                end
            end
            data_busy: begin
                if (!data_mem_busy) begin
                    state_nxt = issue;
                end
            end
            default: state_nxt = issue;
        endcase
    end

    always_comb begin
        pc_ctrl     = ENABLE;
        if_dec_ctrl = ENABLE;
        dec_ex_ctrl = ENABLE;
        ex_mem_ctrl = ENABLE;
        mem_wb_ctrl = ENABLE;
        instr_req   = 1'b1;
        data_req    = mem_access;
        data_we     = mem_access && (mem_mem_ctrl.wr == WRITE);
        if (state == issue) begin
            if (load_use) begin
                // hold the consumer in decode, one bubble into execute
                pc_ctrl     = STALL;
                if_dec_ctrl = STALL;
                dec_ex_ctrl = FLUSH;
            end else if (branch_cond == JUMP) begin
                // redirect and drop the slot behind the jump
                pc_ctrl     = FLUSH;
                if_dec_ctrl = FLUSH;
            end
        end else begin
            // memory busy, freeze everything
            pc_ctrl     = STALL;
            if_dec_ctrl = STALL;
            dec_ex_ctrl = STALL;
            ex_mem_ctrl = STALL;
            mem_wb_ctrl = STALL;
            instr_req   = 1'b0;
            data_req    = 1'b0;
            data_we     = 1'b0;
        end
    end

endmodule

// ==== rtl/pipe_ctrl_top.sv ====
////////////////////
// five-stage pipeline control skeleton
// fetch, decode, execute, memory, writeback under the hazard unit
// retirement stream on wb_valid, wb_pc, wb_rd
////////////////////

`timescale 1ns/1ps

module pipe_ctrl_top import riscv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000
) (
    input  logic            CLK,
    input  logic            RSTn,
    // instruction memory
    input  logic [XLEN-1:0] instr_rdata,
    input  logic            instr_mem_busy,
    output logic [XLEN-1:0] instr_addr,
    output logic            instr_req,
    // data memory
    input  logic            data_mem_busy,
    output logic            data_req,
    output logic            data_we,
    // retirement
    output logic            wb_valid,
    output logic [XLEN-1:0] wb_pc,
    output logic [4:0]      wb_rd
);

    hazard_ctrl_e    pc_ctrl;
    hazard_ctrl_e    if_dec_ctrl;
    hazard_ctrl_e    dec_ex_ctrl;
    hazard_ctrl_e    ex_mem_ctrl;
    hazard_ctrl_e    mem_wb_ctrl;

    if_dec_t         fetch;
    if_dec_t         if_dec_q;
    dec_ex_t         dec_out;
    dec_ex_t         dec_ex_q;
    ex_mem_t         ex_mem_d;
    ex_mem_t         ex_mem_q;
    retire_t         mem_wb_d;
    retire_t         mem_wb_q;

    logic [4:0]      dec_rs1;
    logic [4:0]      dec_rs2;
    logic            dec_use_rs1;
    logic            dec_use_rs2;
    if_ctrl_e        branch_cond;
    logic [XLEN-1:0] jump_target;

    fetch_pc #(
        .RESET_PC (RESET_PC)
    ) i_fetch_pc (
        .CLK         (CLK),
        .RSTn        (RSTn),
        .ctrl        (pc_ctrl),
        .jump_target (jump_target),
        .instr_rdata (instr_rdata),
        .pc          (instr_addr),
        .fetch       (fetch)
    );

    pipe_reg #(.payload_t(if_dec_t)) i_if_dec (
        .CLK  (CLK),
        .RSTn (RSTn),
        .ctrl (if_dec_ctrl),
        .d    (fetch),
        .q    (if_dec_q)
    );

    decoder i_decoder (
        .stage_in    (if_dec_q),
        .stage_out   (dec_out),
        .rs1         (dec_rs1),
        .rs2         (dec_rs2),
        .use_rs1     (dec_use_rs1),
        .use_rs2     (dec_use_rs2),
        .branch_cond (branch_cond),
        .jump_target (jump_target)
    );

    pipe_reg #(.payload_t(dec_ex_t)) i_dec_ex (
        .CLK  (CLK),
        .RSTn (RSTn),
        .ctrl (dec_ex_ctrl),
        .d    (dec_out),
        .q    (dec_ex_q)
    );

    // execute has no datapath here, the payload passes on unchanged
    assign ex_mem_d = '{valid: dec_ex_q.valid, pc: dec_ex_q.pc,
                        rd: dec_ex_q.rd, mem: dec_ex_q.mem};

    pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .CLK  (CLK),
        .RSTn (RSTn),
        .ctrl (ex_mem_ctrl),
        .d    (ex_mem_d),
        .q    (ex_mem_q)
    );

    // memory control is dropped on the way to writeback
    assign mem_wb_d = '{valid: ex_mem_q.valid, pc: ex_mem_q.pc, rd: ex_mem_q.rd};

    pipe_reg #(.payload_t(retire_t)) i_mem_wb (
        .CLK  (CLK),
        .RSTn (RSTn),
        .ctrl (mem_wb_ctrl),
        .d    (mem_wb_d),
        .q    (mem_wb_q)
    );

    hazard_unit i_hazard_unit (
        .CLK            (CLK),
        .RSTn           (RSTn),
        .branch_cond    (branch_cond),
        .dec_rs1        (dec_rs1),
        .dec_rs2        (dec_rs2),
        .dec_use_rs1    (dec_use_rs1),
        .dec_use_rs2    (dec_use_rs2),
        .ex_rd          (dec_ex_q.rd),
        .ex_mem_op      (dec_ex_q.mem),
        .ex_valid       (dec_ex_q.valid),
        .mem_mem_ctrl   (ex_mem_q.mem),
        .mem_valid      (ex_mem_q.valid),
        .instr_mem_busy (instr_mem_busy),
        .data_mem_busy  (data_mem_busy),
        .instr_req      (instr_req),
        .data_req       (data_req),
        .data_we        (data_we),
        .pc_ctrl        (pc_ctrl),
        .if_dec_ctrl    (if_dec_ctrl),
        .dec_ex_ctrl    (dec_ex_ctrl),
        .ex_mem_ctrl    (ex_mem_ctrl),
        .mem_wb_ctrl    (mem_wb_ctrl)
    );

    assign wb_valid = mem_wb_q.valid;
    assign wb_pc    = mem_wb_q.pc;
    assign wb_rd    = mem_wb_q.rd;

endmodule

// ==== test/pipe_ctrl_asserts.sv ====
////////////////////
// concurrent checks on the hazard unit outputs
// bound to every hazard_unit instance
////////////////////

`timescale 1ns/1ps

module pipe_ctrl_asserts import riscv_pkg::*; (
    input logic         CLK,
    input logic         RSTn,
    input logic         instr_mem_busy,
    input logic         data_mem_busy,
    input mem_ctrl_t    mem_mem_ctrl,
    input logic         mem_valid,
    input logic         instr_req,
    input logic         data_req,
    input hazard_ctrl_e pc_ctrl,
    input hazard_ctrl_e if_dec_ctrl,
    input hazard_ctrl_e dec_ex_ctrl,
    input hazard_ctrl_e ex_mem_ctrl,
    input hazard_ctrl_e mem_wb_ctrl
);

    logic any_flush;
    logic all_stall;

    assign any_flush = (pc_ctrl == FLUSH) || (if_dec_ctrl == FLUSH) || (dec_ex_ctrl == FLUSH)
                       || (ex_mem_ctrl == FLUSH) || (mem_wb_ctrl == FLUSH);
    assign all_stall = (pc_ctrl == STALL) && (if_dec_ctrl == STALL) && (dec_ex_ctrl == STALL)
                       && (ex_mem_ctrl == STALL) && (mem_wb_ctrl == STALL);

    // redirects and bubbles only while fetch is requesting
    assert property (@(posedge CLK) disable iff (!RSTn) !instr_req |-> !any_flush)
        else $error("stage flush while instr_req is low");

    // a busy input seen while issuing freezes the next cycle with both requests low
    assert property (@(posedge CLK) disable iff (!RSTn)
        (instr_req && (instr_mem_busy || data_mem_busy))
        |=> (all_stall && !instr_req && !data_req))
        else $error("no full freeze with requests low after a busy cycle");

    assert property (@(posedge CLK) disable iff (!RSTn)
        data_req |-> (mem_valid && mem_mem_ctrl.mem_en))
        else $error("data_req without a valid access in the memory stage");

endmodule

bind hazard_unit pipe_ctrl_asserts i_asserts (.*);

// ==== test/tb_pipe_ctrl.sv ====
////////////////////
// testbench for pipe_ctrl_top
// directed tests on reset, straight-line code, load-use, jumps and busy memories
// expected retirements are worked out from the program words
////////////////////

`timescale 1ns/1ps

module tb_pipe_ctrl import riscv_pkg::*; ();

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    // program lengths in words, each run retires two entries more than that
    localparam int LEN_STRAIGHT = 7;
    localparam int LEN_LOAD_USE = 10;
    localparam int LEN_JUMP     = 9;
    localparam int LEN_MIXED    = 9;
    localparam int WATCHDOG_CYCLES =
        40 * (LEN_STRAIGHT + LEN_LOAD_USE + LEN_JUMP + 2 * LEN_MIXED);

    logic            CLK = 1'b0;
    logic            RSTn;
    logic            instr_mem_busy;
    logic            data_mem_busy;
    logic [XLEN-1:0] instr_rdata;
    logic [XLEN-1:0] instr_addr;
    logic            instr_req;
    logic            data_req;
    logic            data_we;
    logic            wb_valid;
    logic [XLEN-1:0] wb_pc;
    logic [4:0]      wb_rd;

    logic [31:0]     prog_mem [0:255];
    logic [31:0]     prog_words [$];
    logic [31:0]     lfsr_state = 32'he380;
    logic [XLEN-1:0] exp_pc [$];
    logic [4:0]      exp_rd [$];
    int              exp_gap [$];
    logic            exp_mem [$];
    logic            exp_we [$];

    always #10 CLK = ~CLK;

    // combinational instruction memory
    assign instr_rdata = prog_mem[instr_addr[9:2]];

    pipe_ctrl_top #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .CLK            (CLK),
        .RSTn           (RSTn),
        .instr_rdata    (instr_rdata),
        .instr_mem_busy (instr_mem_busy),
        .instr_addr     (instr_addr),
        .instr_req      (instr_req),
        .data_mem_busy  (data_mem_busy),
        .data_req       (data_req),
        .data_we        (data_we),
        .wb_valid       (wb_valid),
        .wb_pc          (wb_pc),
        .wb_rd          (wb_rd)
    );

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // busy about one cycle in four
    task automatic draw_busy(output logic busy);
        logic a;
        lfsr_state = lfsr_next(lfsr_state);
        a = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        busy = a & lfsr_state[0];
    endtask

    function automatic logic [31:0] enc_op(input logic [4:0] rd, rs1, rs2);
        enc_op = {7'd0, rs2, rs1, 3'b000, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_opimm(input logic [4:0] rd, rs1, imm);
        enc_opimm = {7'd0, imm, rs1, 3'b000, rd, OPC_OPIMM};
    endfunction

    function automatic logic [31:0] enc_load(input logic [4:0] rd, rs1);
        enc_load = {12'd0, rs1, 3'b010, rd, OPC_LOAD};
    endfunction

    // low offset bits sit where rd would be
    function automatic logic [31:0] enc_store(input logic [4:0] rs2, rs1);
        enc_store = {7'd0, rs2, rs1, 3'b010, 5'd4, OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        enc_jal = {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // true when instr reads register r as rs1 or rs2
    function automatic logic reads_reg(input logic [31:0] instr, input logic [4:0] r);
        logic [6:0] op;
        op = instr[6:0];
        reads_reg = ((op == OPC_LOAD || op == OPC_STORE || op == OPC_OP || op == OPC_OPIMM)
                     && instr[19:15] == r)
                    || ((op == OPC_STORE || op == OPC_OP) && instr[24:20] == r);
    endfunction

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            // addi x0, x0, index
            prog_mem[i] = {i[11:0], 5'd0, 3'b000, 5'd0, OPC_OPIMM};
        end
        foreach (prog_words[i]) prog_mem[i] = prog_words[i];
    endtask

    // walk the program in order, with the cycle gap each retirement should have
    task automatic build_expected(input int count);
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
        logic [31:0]     prev;
        logic [6:0]      op;
        pc = RESET_PC;
        prev = 32'd0;
        exp_pc.delete();
        exp_rd.delete();
        exp_gap.delete();
        exp_mem.delete();
        exp_we.delete();
        for (int i = 0; i < count; i++) begin
            instr = prog_mem[pc[9:2]];
            op = instr[6:0];
            exp_pc.push_back(pc);
            exp_rd.push_back((op == OPC_LOAD || op == OPC_OP || op == OPC_OPIMM || op == OPC_JAL)
                             ? instr[11:7] : 5'd0);
            exp_mem.push_back(op == OPC_LOAD || op == OPC_STORE);
            exp_we.push_back(op == OPC_STORE);
            // first word is fetched in cycle 0 after reset
            if (i == 0) exp_gap.push_back(4);
            else if (prev[6:0] == OPC_JAL) exp_gap.push_back(2);
            else if (prev[6:0] == OPC_LOAD && prev[11:7] != 5'd0 && reads_reg(instr, prev[11:7]))
                exp_gap.push_back(2);
            else exp_gap.push_back(1);
            if (op == OPC_JAL) begin
                pc = pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end else begin
                pc = pc + 32'd4;
            end
            prev = instr;
        end
    endtask

    task automatic apply_reset();
        @(posedge CLK);
        #1;
        RSTn = 1'b0;
        instr_mem_busy = 1'b0;
        data_mem_busy = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(negedge CLK);
            if (i > 0) begin
                check_value("wb_valid", wb_valid, 1'b0);
                check_value("instr_addr", instr_addr, RESET_PC);
            end
            @(posedge CLK);
        end
        #1;
        RSTn = 1'b1;
    endtask

    // sample at the falling edge, drive busy just after the rising edge
    task automatic run_program(input int count, input logic with_busy);
        int   cycle;
        int   last_ret;
        int   idx;
        logic model_issue;
        logic instr_side;
        logic prev_issue;
        logic prev_req;
        logic prev_we;
        build_expected(count);
        apply_reset();
        cycle = 0;
        last_ret = 0;
        idx = 0;
        model_issue = 1'b1;
        instr_side = 1'b0;
        prev_issue = 1'b1;
        prev_req = 1'b0;
        prev_we = 1'b0;
        while (idx < count) begin
            @(negedge CLK);
            check_value("instr_req", instr_req, model_issue);
            if (!model_issue) check_value("data_req", data_req, 1'b0);
            // wb only moves on an edge taken in the issue state
            if (prev_issue && wb_valid) begin
                check_value("wb_pc", wb_pc, exp_pc[idx]);
                check_value("wb_rd", wb_rd, exp_rd[idx]);
                check_value("data_req", prev_req, exp_mem[idx]);
                check_value("data_we", prev_we, exp_we[idx]);
                if (!with_busy) check_value("retire gap", cycle - last_ret, exp_gap[idx]);
                last_ret = cycle;
                idx++;
            end else if (prev_issue && prev_req) begin
                stop_run("data_req was high but no instruction retired behind it");
            end
            prev_issue = model_issue;
            prev_req = data_req;
            prev_we = data_we;
            // busy state is left the cycle after its busy input falls
            if (model_issue) begin
                model_issue = !(instr_mem_busy || data_mem_busy);
                instr_side = instr_mem_busy;
            end else begin
                model_issue = instr_side ? !instr_mem_busy : !data_mem_busy;
            end
            cycle++;
            @(posedge CLK);
            #1;
            if (with_busy) begin
                draw_busy(instr_mem_busy);
                draw_busy(data_mem_busy);
            end
        end
        instr_mem_busy = 1'b0;
        data_mem_busy = 1'b0;
    endtask

    task automatic test_reset();
        prog_words = '{enc_jal(5'd0, 21'd0)};
        load_program();
        apply_reset();
        @(negedge CLK);
        check_value("instr_req", instr_req, 1'b1);
        check_value("instr_addr", instr_addr, RESET_PC);
        check_value("wb_valid", wb_valid, 1'b0);
    endtask

    task automatic test_straight_line();
        prog_words = '{enc_opimm(5'd1, 5'd0, 5'd1), enc_opimm(5'd2, 5'd1, 5'd2),
                       enc_op(5'd3, 5'd1, 5'd2), enc_opimm(5'd4, 5'd3, 5'd4),
                       enc_op(5'd5, 5'd4, 5'd3), enc_opimm(5'd6, 5'd5, 5'd6),
                       enc_jal(5'd0, 21'd0)};
        load_program();
        run_program(LEN_STRAIGHT + 2, 1'b0);
    endtask

    // hazard on rs1 and rs2, none for x0 or an unrelated register
    task automatic test_load_use();
        prog_words = '{enc_load(5'd5, 5'd1), enc_op(5'd6, 5'd5, 5'd2),
                       enc_load(5'd0, 5'd1), enc_opimm(5'd7, 5'd0, 5'd1),
                       enc_load(5'd8, 5'd1), enc_opimm(5'd9, 5'd2, 5'd3),
                       enc_load(5'd10, 5'd2), enc_store(5'd10, 5'd3),
                       enc_store(5'd4, 5'd5), enc_jal(5'd0, 21'd0)};
        load_program();
        run_program(LEN_LOAD_USE + 2, 1'b0);
    endtask

    task automatic test_jump();
        prog_words = '{enc_opimm(5'd1, 5'd0, 5'd1), enc_jal(5'd2, 21'd12),
                       enc_opimm(5'd3, 5'd0, 5'd3), enc_opimm(5'd4, 5'd0, 5'd4),
                       enc_opimm(5'd5, 5'd1, 5'd5), enc_jal(5'd6, 21'd8),
                       enc_opimm(5'd7, 5'd0, 5'd7), enc_op(5'd8, 5'd5, 5'd1),
                       enc_jal(5'd0, 21'd0)};
        load_program();
        run_program(LEN_JUMP + 2, 1'b0);
    endtask

    task automatic test_back_pressure();
        prog_words = '{enc_load(5'd1, 5'd2), enc_opimm(5'd3, 5'd1, 5'd1),
                       enc_store(5'd3, 5'd2), enc_jal(5'd4, 21'd8),
                       enc_opimm(5'd5, 5'd0, 5'd5), enc_load(5'd6, 5'd3),
                       enc_store(5'd6, 5'd1), enc_op(5'd7, 5'd6, 5'd3), enc_jal(5'd0, 21'd0)};
        load_program();
        run_program(LEN_MIXED + 2, 1'b1);
        run_program(LEN_MIXED + 2, 1'b1);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        stop_run("timeout, the tests did not finish in the expected number of cycles");
    end

    initial begin
        RSTn = 1'b0;
        instr_mem_busy = 1'b0;
        data_mem_busy = 1'b0;
        prog_words = {};
        load_program();
        test_reset();
        test_straight_line();
        test_load_use();
        test_jump();
        test_back_pressure();
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/riscv_pkg.sv
rtl/pipe_reg.sv
rtl/fetch_pc.sv
rtl/decoder.sv
rtl/hazard_unit.sv
rtl/pipe_ctrl_top.sv
test/pipe_ctrl_asserts.sv
test/tb_pipe_ctrl.sv

// ==== Bender.yml ====
package:
  name: pipe_ctrl

sources:
  - rtl/riscv_pkg.sv
  - rtl/pipe_reg.sv
  - rtl/fetch_pc.sv
  - rtl/decoder.sv
  - rtl/hazard_unit.sv
  - rtl/pipe_ctrl_top.sv
  - target: test
    files:
      - test/pipe_ctrl_asserts.sv
      - test/tb_pipe_ctrl.sv
